// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_alu
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+src
src/alu_pkg.sv
src/alu_op_if.sv
src/alu_logic_unit.sv
src/alu_muldiv_unit.sv
src/alu_result_merge.sv
src/alu_wb_top.sv
sim/tb_alu.sv

// ==== sim/tb_alu.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu
    import alu_pkg::*;
();

    // ~120 ops at up to 40 cycles each, about 4x headroom
    localparam int CYCLE_LIMIT = 20000;

    logic       clk;
    logic       reset;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [4:0] wb_adr;
    alu_word_t  wb_dat_w;
    alu_word_t  wb_dat_r;
    logic       wb_ack;

    int         cycle;
    alu_word_t  rng;

    alu_wb_top uut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("Error: simulation hung, no finish after %0d cycles", cycle);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    function automatic alu_word_t xorshift32(input alu_word_t s);
        alu_word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output alu_word_t w);
        rng = xorshift32(rng);
        w   = rng;
    endtask

    function automatic string op_name(input alu_opcode_t opc);
        case (opc)
            `ALU_OP_ADD:  return "add";
            `ALU_OP_SUB:  return "sub";
            `ALU_OP_AND:  return "and";
            `ALU_OP_OR:   return "or";
            `ALU_OP_SHR:  return "shr";
            `ALU_OP_SHRA: return "shra";
            `ALU_OP_SHL:  return "shl";
            `ALU_OP_ROR:  return "ror";
            `ALU_OP_ROL:  return "rol";
            `ALU_OP_NEG:  return "neg";
            `ALU_OP_NOT:  return "not";
            default:      return "undefined";
        endcase
    endfunction

    // expected single-cycle result, 32-bit wraparound
    function automatic alu_word_t expect_single(input alu_opcode_t opc, input alu_word_t y,
                                                input alu_word_t b);
        int        s;
        alu_word_t r;
        s = int'(b % 32);
        case (opc)
            `ALU_OP_ADD:  r = y + b;
            `ALU_OP_SUB:  r = y + ~b + 32'd1;
            `ALU_OP_AND:  r = y & b;
            `ALU_OP_OR:   r = y | b;
            `ALU_OP_SHR:  r = y >> s;
            `ALU_OP_SHRA:
            begin
                r = y >> s;
                if (y[31])
                    r = r | ~(32'hffff_ffff >> s);  // sign fill
            end
            `ALU_OP_SHL:  r = y << s;
            `ALU_OP_ROR:  r = (y >> s) | (y << (32 - s));
            `ALU_OP_ROL:  r = (y << s) | (y >> (32 - s));
            `ALU_OP_NEG:  r = ~b + 32'd1;
            `ALU_OP_NOT:  r = ~b;
            default:      r = '0;
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input alu_word_t expected,
                              input alu_word_t actual);
        if (actual !== expected)
        begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_result(input string name, input alu_result_u expected,
                                input alu_result_u actual);
        if (actual !== expected)
        begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic wait_ack();
        do
            @(negedge clk);
        while (!wb_ack);
    endtask

    task automatic wb_write(input logic [2:0] sel, input alu_word_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= {sel, 2'b00};
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] sel, output alu_word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= {sel, 2'b00};
        wait_ack();
        data = wb_dat_r;  // registered, valid with ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic write_opcode(input alu_opcode_t opc);
        wb_write(`ALU_REG_OP, {{(`ALU_WIDTH-`ALU_OPC_WIDTH){1'b0}}, opc});
    endtask

    task automatic wait_not_busy();
        alu_word_t st;
        do
            wb_read(`ALU_REG_OP, st);
        while (st[0]);
    endtask

    task automatic read_z(output alu_result_u z);
        alu_word_t lo;
        alu_word_t hi;
        wb_read(`ALU_REG_ZLO, lo);
        wb_read(`ALU_REG_ZHI, hi);
        z.prod.lo = lo;
        z.prod.hi = hi;
    endtask

    task automatic run_single(input alu_opcode_t opc, input alu_word_t y, input alu_word_t b);
        alu_result_u z;
        wb_write(`ALU_REG_Y, y);
        wb_write(`ALU_REG_B, b);
        write_opcode(opc);
        repeat (2) @(posedge clk);
        read_z(z);
        check_word({op_name(opc), " lo"}, expect_single(opc, y, b), z.prod.lo);
        check_word({op_name(opc), " hi"}, '0, z.prod.hi);
    endtask

    task automatic test_registers();
        alu_word_t rd;
        alu_word_t y;
        alu_word_t b;
        wb_read(`ALU_REG_Y, rd);
        check_word("reset y", '0, rd);
        wb_read(`ALU_REG_B, rd);
        check_word("reset b", '0, rd);
        wb_read(`ALU_REG_ZLO, rd);
        check_word("reset z lo", '0, rd);
        wb_read(`ALU_REG_ZHI, rd);
        check_word("reset z hi", '0, rd);
        wb_read(`ALU_REG_OP, rd);
        check_word("reset busy", '0, rd);
        next_rand(y);
        next_rand(b);
        wb_write(`ALU_REG_Y, y);
        wb_write(`ALU_REG_B, b);
        wb_read(`ALU_REG_Y, rd);
        check_word("readback y", y, rd);
        wb_read(`ALU_REG_B, rd);
        check_word("readback b", b, rd);
    endtask

    task automatic test_single_cycle();
        alu_opcode_t ops [6];
        alu_word_t   y;
        alu_word_t   b;
        ops = '{`ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_AND, `ALU_OP_OR, `ALU_OP_NEG, `ALU_OP_NOT};
        foreach (ops[k])
        begin
            for (int i = 0; i < 20; i++)
            begin
                next_rand(y);
                next_rand(b);
                run_single(ops[k], y, b);
            end
        end
    endtask

    task automatic test_shifts();
        alu_opcode_t ops [5];
        alu_word_t   y;
        alu_word_t   b;
        ops = '{`ALU_OP_SHR, `ALU_OP_SHRA, `ALU_OP_SHL, `ALU_OP_ROR, `ALU_OP_ROL};
        foreach (ops[k])
        begin
            next_rand(y);
            run_single(ops[k], y, 32'd0);
            next_rand(y);
            y[31] = 1'b1;  // makes shra fill visible
            run_single(ops[k], y, 32'd31);
            next_rand(y);
            next_rand(b);  // upper bits of b must be ignored
            run_single(ops[k], y, b);
        end
    endtask

    task automatic run_mul(input alu_word_t y, input alu_word_t b);
        alu_result_u exp_z;
        alu_result_u z;
        logic [63:0] full;
        full = {32'd0, y} * {32'd0, b};
        exp_z.prod.hi = full[63:32];
        exp_z.prod.lo = full[31:0];
        wb_write(`ALU_REG_Y, y);
        wb_write(`ALU_REG_B, b);
        write_opcode(`ALU_OP_MUL);
        wait_not_busy();
        read_z(z);
        check_result("mul", exp_z, z);
    endtask

    task automatic run_div(input alu_word_t y, input alu_word_t b);
        alu_result_u exp_z;
        alu_result_u z;
        if (b == 0)
        begin
            exp_z.quot.quo = 32'hffff_ffff;
            exp_z.quot.rem = y;
        end
        else
        begin
            exp_z.quot.quo = y / b;
            exp_z.quot.rem = y % b;
        end
        wb_write(`ALU_REG_Y, y);
        wb_write(`ALU_REG_B, b);
        write_opcode(`ALU_OP_DIV);
        wait_not_busy();
        read_z(z);
        check_result("div", exp_z, z);
    endtask

    task automatic test_multiply();
        alu_word_t y;
        alu_word_t b;
        for (int i = 0; i < 6; i++)
        begin
            next_rand(y);
            next_rand(b);
            run_mul(y, b);
        end
        run_mul(32'hffff_ffff, 32'hffff_ffff);
        run_mul(32'hffff_ffff, 32'd2);
        next_rand(b);
        run_mul(32'd0, b);
    endtask

    task automatic test_divide();
        alu_word_t y;
        alu_word_t b;
        for (int i = 0; i < 4; i++)
        begin
            next_rand(y);
            next_rand(b);
            run_div(y, b);
            next_rand(b);
            run_div(y, b & 32'h0000_00ff);  // small divisor, large quotient
        end
        next_rand(y);
        run_div(y, 32'd0);
        run_div(32'hffff_ffff, 32'd1);
        run_div(32'd5, 32'd9);
    endtask

    task automatic test_backpressure();
        alu_word_t   y;
        alu_word_t   b;
        alu_word_t   st;
        alu_result_u z;
        int          t0;
        next_rand(y);
        next_rand(b);
        wb_write(`ALU_REG_Y, y);
        wb_write(`ALU_REG_B, b);
        write_opcode(`ALU_OP_MUL);
        t0 = cycle;
        write_opcode(`ALU_OP_ADD);  // should stall behind the mul
        if (cycle - t0 < 30)
        begin
            $display("Error backpressure: opcode write was acked after %0d cycles, mul still busy",
                     cycle - t0);
            $display("RESULT: FAIL");
            $fatal(1);
        end
        wb_read(`ALU_REG_OP, st);
        check_word("backpressure busy", '0, st);
        repeat (2) @(posedge clk);
        read_z(z);
        check_word("backpressure add lo", y + b, z.prod.lo);
        check_word("backpressure add hi", '0, z.prod.hi);
    endtask

    task automatic test_undefined_opcode();
        alu_word_t y;
        alu_word_t b;
        next_rand(y);
        next_rand(b);
        run_single(`ALU_OP_ADD, y, b);  // leaves a nonzero Z behind
        run_single(5'd2, y, b);
    endtask

    initial
    begin
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        cycle    = 0;
        rng      = 32'd64;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_registers();
        test_single_cycle();
        test_shifts();
        test_multiply();
        test_divide();
        test_backpressure();
        test_undefined_opcode();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== src/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_WIDTH       32
`define ALU_OPC_WIDTH   5

// opcode slots follow the processor encoding
`define ALU_OP_ADD      5'd1
`define ALU_OP_SUB      5'd4
`define ALU_OP_AND      5'd5
`define ALU_OP_OR       5'd6
`define ALU_OP_SHR      5'd7
`define ALU_OP_SHRA     5'd8
`define ALU_OP_SHL      5'd9
`define ALU_OP_ROR      5'd10
`define ALU_OP_ROL      5'd11
`define ALU_OP_MUL      5'd15
`define ALU_OP_DIV      5'd16
`define ALU_OP_NEG      5'd17
`define ALU_OP_NOT      5'd18

// word offsets, taken from adr[4:2]
`define ALU_REG_Y       3'd0
`define ALU_REG_B       3'd1
`define ALU_REG_OP      3'd2
`define ALU_REG_ZLO     3'd3
`define ALU_REG_ZHI     3'd4

`endif

// ==== src/alu_logic_unit.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_logic_unit
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    alu_op_if.unit      op,
    output logic        valid,
    output alu_result_u result
);

    logic        claim;
    logic [4:0]  shamt;
    logic [63:0] rot_r;
    logic [63:0] rot_l;
    alu_word_t   word;

    // everything except mul/div lands here, unknown codes included
    assign claim = (op.opcode != `ALU_OP_MUL) && (op.opcode != `ALU_OP_DIV);

    assign shamt = op.b[4:0];  // amount is B mod 32
    assign rot_r = {op.y, op.y} >> shamt;
    assign rot_l = {op.y, op.y} << shamt;

    always_comb
    begin
        case (op.opcode)
            `ALU_OP_ADD:
            begin
                word = op.y + op.b;
            end
            `ALU_OP_SUB:
            begin
                word = op.y - op.b;
            end
            `ALU_OP_AND:
            begin
                word = op.y & op.b;
            end
            `ALU_OP_OR:
            begin
                word = op.y | op.b;
            end
            `ALU_OP_SHR:
            begin
                word = op.y >> shamt;
            end
            `ALU_OP_SHRA:
            begin
                word = $signed(op.y) >>> shamt;  // sign fill
            end
            `ALU_OP_SHL:
            begin
                word = op.y << shamt;
            end
            `ALU_OP_ROR:
            begin
                word = rot_r[31:0];
            end
            `ALU_OP_ROL:
            begin
                word = rot_l[63:32];
            end
            `ALU_OP_NEG:
            begin
                word = '0 - op.b;
            end
            `ALU_OP_NOT:
            begin
                word = ~op.b;
            end
            default:
            begin
                word = '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= 1'b0;
        else
            valid <= op.start && claim;
    end

    always_ff @(posedge clk)
    begin
        if (op.start && claim)
        begin
            result.prod.hi <= '0;  // single word ops leave hi clear
            result.prod.lo <= word;
        end
    end

endmodule

// ==== src/alu_muldiv_unit.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_muldiv_unit
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    alu_op_if.unit      op,
    output logic        valid,
    output alu_result_u result
);

    logic        mine;
    logic        running;
    logic [4:0]  count;
    logic        is_div;
    alu_word_t   hi_q;    // product high / partial remainder
    alu_word_t   lo_q;    // multiplier / quotient
    alu_word_t   b_q;
    logic [32:0] add_sum;
    logic [32:0] shifted;
    logic [33:0] diff;

    assign mine = (op.opcode == `ALU_OP_MUL) || (op.opcode == `ALU_OP_DIV);

    // shift-add step
    assign add_sum = {1'b0, hi_q} + {1'b0, b_q & {`ALU_WIDTH{lo_q[0]}}};

    // restoring step, diff[33] set means the trial went negative
    assign shifted = {hi_q, lo_q[`ALU_WIDTH-1]};
    assign diff    = {1'b0, shifted} - {2'b00, b_q};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running <= 1'b0;
            count   <= '0;
            valid   <= 1'b0;
        end
        else
        begin
            valid <= 1'b0;
            if (op.start && mine)
            begin
                running <= 1'b1;
                count   <= '0;
            end
            else if (running)
            begin
                count <= count + 5'd1;
                if (count == 5'd31)  // last of 32 steps
                begin
                    running <= 1'b0;
                    valid   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (op.start && mine)
        begin
            hi_q   <= '0;
            lo_q   <= op.y;
            b_q    <= op.b;
            is_div <= (op.opcode == `ALU_OP_DIV);
        end
        else if (running)
        begin
            if (is_div)
            begin
                if (!diff[33])
                begin
                    hi_q <= diff[31:0];
                    lo_q <= {lo_q[30:0], 1'b1};
                end
                else
                begin
                    hi_q <= shifted[31:0];  // restore
                    lo_q <= {lo_q[30:0], 1'b0};
                end
            end
            else
            begin
                hi_q <= add_sum[32:1];
                lo_q <= {add_sum[0], lo_q[31:1]};
            end
        end
    end

    // upper half is product high or remainder
    assign result = {hi_q, lo_q};

    // the top must hold off issue until busy clears
    a_no_start_while_running: assert property (
        @(posedge clk) disable iff (reset)
        (op.start && mine) |-> !running
    );

endmodule

// ==== src/alu_op_if.sv ====
`timescale 1ns/1ps

interface alu_op_if
    import alu_pkg::*;
();

    logic        start;  // one cycle per issued op
    alu_opcode_t opcode;
    alu_word_t   y;
    alu_word_t   b;

    modport issue (
        output start,
        output opcode,
        output y,
        output b
    );

    modport unit (
        input start,
        input opcode,
        input y,
        input b
    );

endinterface

// ==== src/alu_pkg.sv ====
`include "alu_defs.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] alu_word_t;

    typedef logic [`ALU_OPC_WIDTH-1:0] alu_opcode_t;

    // mul and single-cycle view
    typedef struct packed {
        alu_word_t hi;
        alu_word_t lo;
    } alu_prod_t;

    // div view, remainder in the HI half
    typedef struct packed {
        alu_word_t rem;
        alu_word_t quo;
    } alu_quot_t;

    typedef union packed {
        alu_prod_t prod;
        alu_quot_t quot;
    } alu_result_u;

endpackage

// ==== src/alu_result_merge.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_result_merge
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        logic_valid,
    input  alu_result_u logic_result,
    input  logic        muldiv_valid,
    input  alu_result_u muldiv_result,
    alu_op_if.unit      op,
    output alu_result_u z,
    output logic        busy
);

    logic is_long;

    assign is_long = (op.opcode == `ALU_OP_MUL) || (op.opcode == `ALU_OP_DIV);

    always_ff @(posedge clk)
    begin
        if (reset)
            z <= '0;
        else if (logic_valid)
            z <= logic_result;
        else if (muldiv_valid)
            z <= muldiv_result;
    end

    // set on a mul/div issue, cleared by its valid
    always_ff @(posedge clk)
    begin
        if (reset)
            busy <= 1'b0;
        else if (op.start && is_long)
            busy <= 1'b1;
        else if (muldiv_valid)
            busy <= 1'b0;
    end

    // one op in flight per unit, and the issue stall keeps them apart
    a_single_valid: assert property (
        @(posedge clk) disable iff (reset)
        !(logic_valid && muldiv_valid)
    );

endmodule

// ==== src/alu_wb_top.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_wb_top
    import alu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [4:0] wb_adr,
    input  alu_word_t  wb_dat_w,
    output alu_word_t  wb_dat_r,
    output logic       wb_ack
);

    alu_op_if op_bus ();

    logic        logic_valid;
    logic        muldiv_valid;
    logic        busy;
    logic        hold_q;    // acked, waiting for stb to drop
    logic        start_q;
    logic        req;
    logic        op_write;
    logic        accept;
    logic [2:0]  reg_sel;
    alu_word_t   y_q;
    alu_word_t   b_q;
    alu_opcode_t opc_q;
    alu_result_u logic_result;
    alu_result_u muldiv_result;
    alu_result_u z;

    assign reg_sel  = wb_adr[4:2];
    assign req      = wb_cyc && wb_stb && !hold_q;
    assign op_write = wb_we && (reg_sel == `ALU_REG_OP);
    assign accept   = req && !(op_write && busy);  // stall issue while busy

    assign op_bus.start  = start_q;
    assign op_bus.opcode = opc_q;
    assign op_bus.y      = y_q;
    assign op_bus.b      = b_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack  <= 1'b0;
            hold_q  <= 1'b0;
            start_q <= 1'b0;
            y_q     <= '0;
            b_q     <= '0;
            opc_q   <= '0;
        end
        else
        begin
            wb_ack  <= accept;
            start_q <= accept && op_write;  // pulses in the ack cycle
            if (accept)
                hold_q <= 1'b1;
            else if (!wb_stb)
                hold_q <= 1'b0;
            if (accept && wb_we)
            begin
                case (reg_sel)
                    `ALU_REG_Y:  y_q   <= wb_dat_w;
                    `ALU_REG_B:  b_q   <= wb_dat_w;
                    `ALU_REG_OP: opc_q <= wb_dat_w[`ALU_OPC_WIDTH-1:0];
                    default:     ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && !wb_we)
        begin
            case (reg_sel)
                `ALU_REG_Y:   wb_dat_r <= y_q;
                `ALU_REG_B:   wb_dat_r <= b_q;
                `ALU_REG_OP:  wb_dat_r <= {{(`ALU_WIDTH-1){1'b0}}, busy};
                `ALU_REG_ZLO: wb_dat_r <= z.prod.lo;
                `ALU_REG_ZHI: wb_dat_r <= z.prod.hi;
                default:      wb_dat_r <= '0;
            endcase
        end
    end

    alu_logic_unit u_logic (
        .clk    (clk),
        .reset  (reset),
        .op     (op_bus.unit),
        .valid  (logic_valid),
        .result (logic_result)
    );

    alu_muldiv_unit u_muldiv (
        .clk    (clk),
        .reset  (reset),
        .op     (op_bus.unit),
        .valid  (muldiv_valid),
        .result (muldiv_result)
    );

    alu_result_merge u_merge (
        .clk           (clk),
        .reset         (reset),
        .logic_valid   (logic_valid),
        .logic_result  (logic_result),
        .muldiv_valid  (muldiv_valid),
        .muldiv_result (muldiv_result),
        .op            (op_bus.unit),
        .z             (z),
        .busy          (busy)
    );

    // host holds the request through the ack cycle
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset)
        $rose(wb_ack) |-> (wb_cyc && wb_stb)
    );

endmodule
